// File: list.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/way_ram.sv
rtl/cache_tag.sv
rtl/cache_way_sel.sv
rtl/cache_data.sv
rtl/cache_ctrl.sv
rtl/icache_top.sv
verif/tb_clk_gen.sv
verif/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/way_ram.sv
      - rtl/cache_tag.sv
      - rtl/cache_way_sel.sv
      - rtl/cache_data.sv
      - rtl/cache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_icache.sv

// File: verif/tb_icache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tb_icache;

   localparam logic [31:0] XLATE       = 32'h0001_0000; // Virtual to physical flip
   localparam logic [31:0] MEM_PAT     = 32'hA5A5_0000; // Memory contents pattern
   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
   localparam int          N_RAND      = 200;
   localparam int          N_REQ       = 214;            // Every CPU read of the run
   localparam int          CYCLE_LIMIT = N_REQ * 20 + 100;

   logic        clk, rst_n;
   logic        cpu_cyc, cpu_stb, cpu_ack;
   logic [31:0] cpu_adr, cpu_padr, cpu_dat;
   logic        mem_cyc, mem_stb, mem_ack;
   logic [31:0] mem_adr, mem_dat;
   logic        snoop_valid, snoop_hit;
   logic [31:0] snoop_adr;

   logic [31:0] stim_lfsr = 32'h410a; // Stimulus and memory waits step their own registers
   logic [31:0] mem_lfsr  = 32'h410a;
   logic [31:0] mem_log [$];          // Addresses of the memory reads of the current request
   logic [31:0] wait_bits;            // Raw LFSR bits for the memory wait count
   logic [1:0]  wait_left;
   bit          waiting;
   int          err_count, check_count, test_base, tests_run, cycle_cnt;
   int          exp_misses, obs_misses;

   // Cache model with the tags and valid bits per set and way plus the victim pointer
   logic [23:0] m_vtag  [`CACHE_LINES][`CACHE_WAYS];
   bit          m_valid [`CACHE_LINES][`CACHE_WAYS];
   int          m_rr    [`CACHE_LINES];

   tb_clk_gen #(.PERIOD(20), .RST_CYCLES(4)) u_clk_gen (.clk(clk), .rst_n(rst_n));

   icache_top u_dut (
      .clk (clk), .rst_n (rst_n),
      .cpu_cyc (cpu_cyc), .cpu_stb (cpu_stb), .cpu_adr (cpu_adr), .cpu_padr (cpu_padr),
      .cpu_ack (cpu_ack), .cpu_dat (cpu_dat),
      .mem_cyc (mem_cyc), .mem_stb (mem_stb), .mem_adr (mem_adr),
      .mem_ack (mem_ack), .mem_dat (mem_dat),
      .snoop_valid (snoop_valid), .snoop_adr (snoop_adr), .snoop_hit (snoop_hit)
   );

   // ============================================================
   // Helpers
   // ============================================================
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1); // Galois form with bit 0 as the output
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v  = {v[30:0], st[0]};
         st = lfsr_step(st);
      end
   endtask

   function automatic logic [31:0] mem_word(input logic [31:0] adr);
      return {adr[31:2], 2'b00} ^ MEM_PAT; // Memory holds its own word address
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         err_count++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      $display("test %-22s done, %0d errors", name, err_count - test_base);
      test_base = err_count;
   endtask

   // Index is bits 7:4 and the tag is everything above it
   // Two ways per set are filled round-robin
   function automatic bit model_access(input logic [31:0] vadr);
      int          ndx;
      logic [23:0] tag;
      bit          hit;
      ndx = vadr[7:4];
      tag = vadr[31:8];
      hit = 1'b0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
         if (m_valid[ndx][w] && m_vtag[ndx][w] == tag) hit = 1'b1;
      end
      if (!hit) begin
         m_vtag[ndx][m_rr[ndx]]  = tag;
         m_valid[ndx][m_rr[ndx]] = 1'b1;
         m_rr[ndx] = (m_rr[ndx] + 1) % `CACHE_WAYS;
      end
      return !hit;
   endfunction

   // ============================================================
   // Memory slave and run limit
   // ============================================================
   always begin
      @(posedge clk);
      #1;
      if (mem_ack) begin
         mem_ack = 1'b0; // The DUT took the word at this edge
      end else if (mem_cyc && mem_stb) begin
         if (!waiting) begin
            take_bits(mem_lfsr, 2, wait_bits);
            wait_left = wait_bits[1:0]; // Zero to three wait cycles
            waiting   = 1'b1;
         end
         if (wait_left == 2'd0) begin
            mem_ack = 1'b1;
            mem_dat = mem_word(mem_adr);
            mem_log.push_back(mem_adr);
            waiting = 1'b0;
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // ============================================================
   // CPU and snoop transactions
   // ============================================================
   task automatic cpu_read(input logic [31:0] vadr, output logic [31:0] dat, output int lat);
      lat      = 0;
      cpu_cyc  = 1'b1;
      cpu_stb  = 1'b1;
      cpu_adr  = vadr;
      cpu_padr = vadr ^ XLATE; // Stands in for the missing translation unit
      do begin
         @(posedge clk);
         #1;
         lat++;
      end while (cpu_ack !== 1'b1);
      dat     = cpu_dat;
      cpu_stb = 1'b0;
      @(posedge clk); // cyc stays up through the ack cycle
      #1;
      cpu_cyc = 1'b0;
   endtask

   task automatic checked_read(input logic [31:0] vadr, output bit miss);
      logic [31:0] padr, dat;
      int          lat, n_mem;
      bit          exp_miss;
      padr     = vadr ^ XLATE;
      exp_miss = model_access(vadr);
      exp_misses += exp_miss;
      mem_log.delete();
      cpu_read(vadr, dat, lat);
      n_mem = mem_log.size();
      miss  = (n_mem != 0);
      obs_misses += miss;
      check_val("cpu_dat", dat, mem_word(padr));
      check_val("mem_reads", n_mem, exp_miss ? 4 : 0);
      if (exp_miss && n_mem == 4) begin
         for (int w = 0; w < 4; w++) begin // Ascending words of the physical line
            check_val("mem_adr", mem_log[w], {padr[31:4], 4'h0} + w * 4);
         end
      end else if (!exp_miss) begin
         check_val("ack_latency", lat, 1);
      end
   endtask

   task automatic snoop_probe(input logic [31:0] adr, input logic exp);
      snoop_valid = 1'b1;
      snoop_adr   = adr;
      @(posedge clk);
      #1;
      snoop_valid = 1'b0;
      check_val("snoop_hit", snoop_hit, exp); // Registered one edge after the probe
   endtask

   // ============================================================
   // Test sequence
   // ============================================================
   initial begin
      logic [31:0] vadr, r;
      bit          miss;
      int          exp_base, obs_base;
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
      cpu_adr = '0;
      cpu_padr = '0;
      mem_ack = 1'b0;
      mem_dat = '0;
      snoop_valid = 1'b0;
      snoop_adr = '0;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;

      // Empty cache right after reset
      check_val("snoop_hit", snoop_hit, 1'b0);
      snoop_probe(32'h0001_1000, 1'b0);
      checked_read(32'h0000_1000, miss);
      check_val("miss", miss, 1'b1);
      checked_read(32'h0000_1010, miss);
      check_val("miss", miss, 1'b1);
      end_test("reset state");

      checked_read(32'h0000_2024, miss); // Word 1 of a new line
      check_val("miss", miss, 1'b1);
      end_test("first fill");

      for (int w = 0; w < 4; w++) begin
         checked_read(32'h0000_2020 + w * 4, miss);
         check_val("miss", miss, 1'b0);
      end
      checked_read(32'h0000_1000, miss);
      check_val("miss", miss, 1'b0);
      end_test("hit latency");

      // Three lines in set 5 where the third one pushes out the first
      checked_read(32'h0002_0050, miss);
      check_val("miss", miss, 1'b1);
      checked_read(32'h0002_0150, miss);
      check_val("miss", miss, 1'b1);
      checked_read(32'h0002_0250, miss);
      check_val("miss", miss, 1'b1);
      checked_read(32'h0002_0250, miss);
      check_val("miss", miss, 1'b0);
      checked_read(32'h0002_0150, miss); // Kept line from the second fill
      check_val("miss", miss, 1'b0);
      checked_read(32'h0002_0050, miss); // Refill evicts the second line
      check_val("miss", miss, 1'b1);
      end_test("round robin eviction");

      snoop_probe(32'h0003_0250, 1'b1); // Physical address of a cached line
      snoop_probe(32'h0002_0250, 1'b0); // Its virtual address
      snoop_probe(32'h0003_0150, 1'b0); // Evicted line
      end_test("snoop");

      exp_base = exp_misses;
      obs_base = obs_misses;
      for (int i = 0; i < N_RAND; i++) begin
         take_bits(stim_lfsr, 6, r);
         vadr = 32'h0000_1000 | (r[5:4] << 8) | (r[3:2] << 4) | (r[1:0] << 2); // 16 lines over 4 sets
         checked_read(vadr, miss);
      end
      check_val("miss_count", obs_misses - obs_base, exp_misses - exp_base);
      end_test("random mix");

      $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
      if (err_count == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD     = 20, // Clock period in ns
   parameter int RST_CYCLES = 4   // Rising edges spent in reset
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk; // Free running, first rising edge at half a period
   end

   // Reset releases just after an edge so no flop sees it change at the edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: rtl/icache_top.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module icache_top (
   input  logic                       clk,
   input  logic                       rst_n,
   // CPU side
   input  logic                       cpu_cyc,
   input  logic                       cpu_stb,
   input  logic [`CACHE_ADR_W-1:0]    cpu_adr,
   input  logic [`CACHE_ADR_W-1:0]    cpu_padr,
   output logic                       cpu_ack,
   output logic [31:0]                cpu_dat,
   // Memory side
   output logic                       mem_cyc,
   output logic                       mem_stb,
   output logic [`CACHE_ADR_W-1:0]    mem_adr,
   input  logic                       mem_ack,
   input  logic [31:0]                mem_dat,
   // Snoop
   input  logic                       snoop_valid,
   input  logic [`CACHE_ADR_W-1:0]    snoop_adr,
   output logic                       snoop_hit
);

   import cache_pkg::*;

   localparam int NDX_W  = $bits(cache_ndx_t);
   localparam int WORD_W = $clog2(`CACHE_LINE_WORDS);
   localparam int TAG_LO = `CACHE_LOBIT + NDX_W; // Lowest tag bit

   // ============================================================
   // Address fields
   // ============================================================
   cache_tag_t               vtag, ptag, stag;   // Lookup, fill and snoop tags
   cache_ndx_t               ndx, sndx;
   logic [WORD_W-1:0]        word;
   cache_tag_t [`CACHE_WAYS-1:0] vtags, ptags;
   logic [`CACHE_WAYS-1:0]   vvalid, pvalid, phys_match;
   cache_way_t               hit_way, victim_way;
   cache_line_t              fill_line;
   logic                     hit, wr, upd, snoop_hit_comb;

   assign vtag = cpu_adr[`CACHE_ADR_W-1:TAG_LO];
   assign ptag = cpu_padr[`CACHE_ADR_W-1:TAG_LO];  // Physical tag stored for snooping
   assign stag = snoop_adr[`CACHE_ADR_W-1:TAG_LO];
   assign ndx  = cpu_adr[TAG_LO-1:`CACHE_LOBIT];   // Index is virtual
   assign sndx = snoop_adr[TAG_LO-1:`CACHE_LOBIT];
   assign word = cpu_adr[`CACHE_LOBIT-1:2];

   cache_ctrl u_ctrl (
      .clk (clk), .rst_n (rst_n),
      .cpu_cyc (cpu_cyc), .cpu_stb (cpu_stb), .cpu_adr (cpu_adr), .cpu_padr (cpu_padr),
      .hit (hit), .cpu_ack (cpu_ack),
      .mem_cyc (mem_cyc), .mem_stb (mem_stb), .mem_adr (mem_adr),
      .mem_ack (mem_ack), .mem_dat (mem_dat),
      .wr (wr), .upd (upd), .fill_line (fill_line),
      .snoop_valid (snoop_valid), .snoop_hit_comb (snoop_hit_comb), .snoop_hit (snoop_hit)
   );

   cache_tag u_tag (
      .clk (clk), .rst_n (rst_n), .wr (wr), .wr_way (victim_way), .wr_ndx (ndx),
      .vtag_in (vtag), .ptag_in (ptag),
      .ndx (ndx), .vtags (vtags), .vvalid (vvalid),
      .sndx (sndx), .ptags (ptags), .pvalid (pvalid)
   );

   cache_way_sel u_way_sel (
      .clk (clk), .rst_n (rst_n), .lookup_tag (vtag), .vtags (vtags), .vvalid (vvalid),
      .snoop_tag (stag), .ptags (ptags), .pvalid (pvalid), .upd_ndx (ndx), .upd (upd),
      .hit (hit), .hit_way (hit_way), .victim_way (victim_way),
      .snoop_hit_comb (snoop_hit_comb), .phys_match (phys_match)
   );

   cache_data u_data (
      .clk (clk), .wr (wr), .wr_way (victim_way), .wr_ndx (ndx), .wr_line (fill_line),
      .rd_ndx (ndx), .rd_way (hit_way), .rd_word (word), .rd_dat (cpu_dat)
   );

   // A physical line sits in one way only, as long as translation maps one to one
   a_phys_unique : assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(phys_match) |-> $onehot0(phys_match))
      else $error("physical line cached in more than one way");

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,
   // CPU side Wishbone slave
   input  logic                          cpu_cyc,
   input  logic                          cpu_stb,
   input  logic [`CACHE_ADR_W-1:0]       cpu_adr,   // Virtual address
   input  logic [`CACHE_ADR_W-1:0]       cpu_padr,  // Translated address
   input  logic                          hit,       // Lookup result for cpu_adr
   output logic                          cpu_ack,
   // Memory side Wishbone master
   output logic                          mem_cyc,
   output logic                          mem_stb,
   output logic [`CACHE_ADR_W-1:0]       mem_adr,
   input  logic                          mem_ack,
   input  logic [31:0]                   mem_dat,
   // Array updates
   output logic                          wr,
   output logic                          upd,
   output cache_pkg::cache_line_t        fill_line,
   // Snoop
   input  logic                          snoop_valid,
   input  logic                          snoop_hit_comb,
   output logic                          snoop_hit
);

   import cache_pkg::*;

   localparam int WORD_W = $clog2(`CACHE_LINE_WORDS);
   localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`CACHE_LINE_WORDS - 1);

   ctrl_state_t       state_q;
   logic [WORD_W-1:0] word_q;  // Word being fetched during a fill
   cache_line_t       fill_q;  // Line assembly buffer

   // ============================================================
   // Control FSM
   // ============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
         word_q  <= '0;
         mem_cyc <= 1'b0;
         mem_stb <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (cpu_cyc && cpu_stb) begin
                  if (hit) begin
                     state_q <= ACK; // Ack goes out on this edge
                  end else begin
                     state_q <= FILL;
                     mem_cyc <= 1'b1; // Start the first word read right away
                     mem_stb <= 1'b1;
                     word_q  <= '0;
                  end
               end
            end
            ACK: begin
               state_q <= IDLE; // Strobe is ignored while ack is high
            end
            FILL: begin
               if (mem_stb && mem_ack) begin
                  mem_stb <= 1'b0;           // Drop stb for a cycle after each ack
                  word_q  <= word_q + 1'b1;  // Wraps to zero after the last word
                  if (word_q == LAST_WORD) begin
                     mem_cyc <= 1'b0;
                     state_q <= WRITE;
                  end
               end else if (!mem_stb) begin
                  mem_stb <= 1'b1; // Next word of the line
               end
            end
            WRITE: begin
               state_q <= IDLE; // Lookup repeats and now hits
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Fill buffer captures each returned word in its slot
   always_ff @(posedge clk) begin
      if (state_q == FILL && mem_stb && mem_ack) begin
         fill_q[word_q] <= mem_dat;
      end
   end

   // The CPU holds cpu_padr through the fill, so the address needs no register
   assign mem_adr = {cpu_padr[`CACHE_ADR_W-1:`CACHE_LOBIT], word_q, 2'b00};

   assign cpu_ack   = (state_q == ACK);
   assign wr        = (state_q == WRITE); // Tags, data and valid bit in one edge
   assign upd       = wr;                 // Victim pointer moves with the write
   assign fill_line = fill_q;

   // Snoop result is registered for a fixed one-cycle latency
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snoop_hit <= 1'b0;
      end else begin
         snoop_hit <= snoop_valid && snoop_hit_comb;
      end
   end

   // ============================================================
   // Checks
   // ============================================================
   a_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n) cpu_ack |=> !cpu_ack)
      else $error("cpu_ack held for two cycles");

   a_ack_cyc : assert property (@(posedge clk) disable iff (!rst_n) cpu_ack |-> cpu_cyc)
      else $error("cpu_ack outside a bus cycle");

   // Index, tags and fill address all come from the live request addresses
   a_adr_stable : assert property (@(posedge clk) disable iff (!rst_n)
      mem_cyc |-> $stable(cpu_adr) && $stable(cpu_padr))
      else $error("CPU address changed during a line fill");

endmodule

// File: rtl/cache_data.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data (
   input  logic                                    clk,
   input  logic                                    wr,       // Write a whole line
   input  cache_pkg::cache_way_t                   wr_way,
   input  cache_pkg::cache_ndx_t                   wr_ndx,
   input  cache_pkg::cache_line_t                  wr_line,
   input  cache_pkg::cache_ndx_t                   rd_ndx,
   input  cache_pkg::cache_way_t                   rd_way,   // Way that hit
   input  logic [$clog2(`CACHE_LINE_WORDS)-1:0]    rd_word,  // Word within the line
   output logic [31:0]                             rd_dat
);

   import cache_pkg::*;

   cache_line_t [`CACHE_WAYS-1:0] rd_lines; // Line of every way at the read index

   // ============================================================
   // Line storage
   // ============================================================
   for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
      way_ram #(.payload_t(cache_line_t)) u_line (
         .clk    (clk),
         .wr     (wr && (wr_way == cache_way_t'(g))),
         .wr_ndx (wr_ndx),
         .wr_dat (wr_line),
         .rd_ndx (rd_ndx),
         .rd_dat (rd_lines[g])
      );
   end

   // Way mux first, then the word mux
   assign rd_dat = rd_lines[rd_way][rd_word];

endmodule

// File: rtl/cache_way_sel.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_way_sel (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  cache_pkg::cache_tag_t                     lookup_tag,  // Virtual tag of the request
   input  cache_pkg::cache_tag_t [`CACHE_WAYS-1:0]   vtags,
   input  logic [`CACHE_WAYS-1:0]                    vvalid,
   input  cache_pkg::cache_tag_t                     snoop_tag,   // Physical tag of the snoop
   input  cache_pkg::cache_tag_t [`CACHE_WAYS-1:0]   ptags,
   input  logic [`CACHE_WAYS-1:0]                    pvalid,
   input  cache_pkg::cache_ndx_t                     upd_ndx,     // Set being looked up and filled
   input  logic                                      upd,         // Advance this set's victim
   output logic                                      hit,
   output cache_pkg::cache_way_t                     hit_way,
   output cache_pkg::cache_way_t                     victim_way,
   output logic                                      snoop_hit_comb,
   output logic [`CACHE_WAYS-1:0]                    phys_match   // Per-way snoop match
);

   import cache_pkg::*;

   logic [`CACHE_WAYS-1:0] virt_match;         // Per-way lookup match
   cache_way_t [`CACHE_LINES-1:0] rr_q;        // Round-robin pointer per set

   // ============================================================
   // Tag compare
   // ============================================================
   always_comb begin
      hit_way = '0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
         virt_match[w] = vvalid[w] && (vtags[w] == lookup_tag); // Valid gates stale RAM words
         phys_match[w] = pvalid[w] && (ptags[w] == snoop_tag);
         if (virt_match[w]) begin
            hit_way = cache_way_t'(w); // At most one way matches
         end
      end
   end

   assign hit            = |virt_match;
   assign snoop_hit_comb = |phys_match;

   // Victim selection, the pointer moves on after every fill of the set
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rr_q <= '0;
      end else if (upd) begin
         if (rr_q[upd_ndx] == cache_way_t'(`CACHE_WAYS - 1)) begin
            rr_q[upd_ndx] <= '0; // Wrap for any way count
         end else begin
            rr_q[upd_ndx] <= rr_q[upd_ndx] + 1'b1;
         end
      end
   end

   assign victim_way = rr_q[upd_ndx];

   // Fills only happen on a miss, so a set never holds one virtual line twice
   a_one_hit : assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(virt_match) |-> $onehot0(virt_match))
      else $error("more than one way hits the lookup");

endmodule

// File: rtl/cache_tag.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      wr,      // Write both tags of one way
   input  cache_pkg::cache_way_t                     wr_way,
   input  cache_pkg::cache_ndx_t                     wr_ndx,
   input  cache_pkg::cache_tag_t                     vtag_in,
   input  cache_pkg::cache_tag_t                     ptag_in,
   input  cache_pkg::cache_ndx_t                     ndx,     // Lookup index
   output cache_pkg::cache_tag_t [`CACHE_WAYS-1:0]   vtags,
   output logic [`CACHE_WAYS-1:0]                    vvalid,
   input  cache_pkg::cache_ndx_t                     sndx,    // Snoop index
   output cache_pkg::cache_tag_t [`CACHE_WAYS-1:0]   ptags,
   output logic [`CACHE_WAYS-1:0]                    pvalid
);

   import cache_pkg::*;

   // Valid bits are flops so that reset can clear every line at once
   logic [`CACHE_LINES-1:0][`CACHE_WAYS-1:0] valid_q;

   // ============================================================
   // Tag arrays, one virtual and one physical RAM per way
   // ============================================================
   for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
      logic way_wr;

      assign way_wr = wr && (wr_way == cache_way_t'(g)); // Only the victim way is written

      // Virtual tags are read at the lookup index
      way_ram #(.payload_t(cache_tag_t)) u_vtag (
         .clk    (clk),
         .wr     (way_wr),
         .wr_ndx (wr_ndx),
         .wr_dat (vtag_in),
         .rd_ndx (ndx),
         .rd_dat (vtags[g])
      );

      // Physical tags are read at the snoop index
      way_ram #(.payload_t(cache_tag_t)) u_ptag (
         .clk    (clk),
         .wr     (way_wr),
         .wr_ndx (wr_ndx),
         .wr_dat (ptag_in),
         .rd_ndx (sndx),
         .rd_dat (ptags[g])
      );
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0; // Every line starts empty
      end else if (wr) begin
         valid_q[wr_ndx][wr_way] <= 1'b1; // There is no invalidate, so bits only ever set
      end
   end

   assign vvalid = valid_q[ndx];  // Valid bits follow the same index as their tags
   assign pvalid = valid_q[sndx];

endmodule

// File: rtl/way_ram.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module way_ram #(
   parameter type payload_t = logic [31:0]
) (
   input  logic                   clk,
   input  logic                   wr,     // Write strobe, data lands at the edge
   input  cache_pkg::cache_ndx_t  wr_ndx,
   input  payload_t               wr_dat,
   input  cache_pkg::cache_ndx_t  rd_ndx,
   output payload_t               rd_dat  // Asynchronous read
);

   // Distributed RAM style storage, one entry per set
   // Contents are undefined after reset, valid bits live elsewhere
   payload_t mem [`CACHE_LINES];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_ndx] <= wr_dat; // Single write port
      end
   end

   assign rd_dat = mem[rd_ndx]; // Read port never waits for a clock

   // ============================================================
   // Checks
   // ============================================================

   // A write with an unknown index would corrupt an arbitrary set
   a_wr_ndx_known : assert property (@(posedge clk) wr |-> !$isunknown(wr_ndx))
      else $error("way_ram write with unknown index");

endmodule

// File: rtl/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

   // ============================================================
   // Cache datapath types
   // ============================================================

   // Address bits above the set index, shared by virtual and physical tags
   typedef logic [`CACHE_ADR_W-1:`CACHE_LOBIT+$clog2(`CACHE_LINES)] cache_tag_t;

   // One full line, word 0 in the low bits
   typedef logic [`CACHE_LINE_WORDS-1:0][31:0] cache_line_t;

   typedef logic [$clog2(`CACHE_LINES)-1:0] cache_ndx_t; // Set index
   typedef logic [$clog2(`CACHE_WAYS)-1:0] cache_way_t;  // Way number

   // Controller states
   typedef enum logic [1:0] {
      IDLE,  // Waiting for a CPU strobe, the lookup runs here
      ACK,   // One-cycle acknowledge to the CPU
      FILL,  // Fetching the line word by word
      WRITE  // Writing tags and data of the filled line
   } ctrl_state_t;

endpackage

// File: rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// ============================================================
// Cache geometry
// ============================================================

// Byte address width on the CPU side and on the memory side
`define CACHE_ADR_W 32

// Number of sets, each set holds one line per way
`define CACHE_LINES 16

// Associativity
`define CACHE_WAYS 2

// A line is this many 32-bit words
`define CACHE_LINE_WORDS 4

// Lowest set index bit, everything below it selects a byte in the line
`define CACHE_LOBIT 4

`endif
